// ==== rtl/pdp8_macros.svh ====
/* Width, memory size, step and opcode constants for the PDP-8 core.
   Included by the package and by every RTL file that needs a constant. */
`ifndef PDP8_MACROS_SVH
`define PDP8_MACROS_SVH

`define WORD_W     12
`define ADDR_W     12
`define MEM_DEPTH  4096
`define AUTO_LO    12'o0010      // Auto-index locations
`define AUTO_HI    12'o0017

// Step counter values, two steps per phase
`define STEP_FETCH 5'd0
`define STEP_AUTO1 5'd2
`define STEP_IND   5'd6
`define STEP_EXEC1 5'd8
`define STEP_LAST  5'd19        // Strobe of EXEC6
`define STEP_IDLE  5'd31

// Opcodes in IR[11:9]
`define OP_AND     3'o0
`define OP_TAD     3'o1
`define OP_ISZ     3'o2
`define OP_DCA     3'o3
`define OP_JMS     3'o4
`define OP_JMP     3'o5
`define OP_OPR     3'o7

`endif

// ==== rtl/pdp8Pkg.sv ====
/* Types shared by the PDP-8 core blocks and its testbench.
   Referenced by scoped names, never imported. */
`include "pdp8_macros.svh"

package pdp8Pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`ADDR_W-1:0] addr_t;

  // Pair of sequencer steps currently active
  typedef enum logic [3:0] {
    FETCH,
    AUTO1,
    AUTO2,
    IND,
    EXEC1,
    EXEC2,
    EXEC3,
    EXEC4,
    EXEC5,
    EXEC6,
    IDLE
  } phase_t;

  // Address path taken after fetch
  typedef enum logic [1:0] {
    DIRECT,       // FETCH then EXEC1
    INDIRECT,     // FETCH, IND
    AUTOINDEX     // FETCH, AUTO1, AUTO2, IND
  } seqType_t;

  typedef enum logic [1:0] {NONE, READ, WRITE} memAct_t;

  typedef enum logic [1:0] {WR_AC, WR_MBINC, WR_PC} wrSrc_t;

  typedef enum logic [1:0] {MA_PC, MA_ADDR, MA_MB} maSrc_t;

endpackage

// ==== rtl/sequencer.sv ====
/* Step sequencer of the PDP-8 core. Runs a 5-bit step counter through the
   fetch, auto-index, indirect and execute phases and holds the run state. */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module sequencer (
  input  logic               SYSCLK,
  input  logic               RESET,
  input  logic               run,       // Rising edge starts the core
  input  logic               halt,      // Rising edge stops at end of instruction
  input  logic               done,      // Last execute strobe of the instruction
  input  pdp8Pkg::seqType_t  seqType,
  output pdp8Pkg::phase_t    phase,
  output logic               strobe,
  output logic               running
);

  logic [4:0] stepCnt;
  logic       runQ;
  logic       haltQ;
  logic       haltPend;   // Halt seen, waiting for done
  logic       runRise;
  logic       haltRise;
  logic       stopNow;

  assign runRise  = run & ~runQ;
  assign haltRise = halt & ~haltQ;
  assign stopNow  = haltPend | haltRise;

  always_ff @(posedge SYSCLK) begin
    if (RESET) begin
      runQ     <= 1'b0;
      haltQ    <= 1'b0;
      haltPend <= 1'b0;
      running  <= 1'b0;
      stepCnt  <= `STEP_IDLE;
    end else begin
      runQ  <= run;
      haltQ <= halt;
      if (!running) begin
        haltPend <= 1'b0;
        if (runRise) begin
          running <= 1'b1;
          stepCnt <= `STEP_FETCH;
        end
      end else if (done) begin
        haltPend <= 1'b0;
        if (stopNow) begin
          running <= 1'b0;
          stepCnt <= `STEP_IDLE;
        end else begin
          stepCnt <= `STEP_FETCH;
        end
      end else begin
        if (haltRise)
          haltPend <= 1'b1;
        if (stepCnt == `STEP_FETCH + 5'd1) begin
          // Branch on the address path of the fetched word
          case (seqType)
            pdp8Pkg::DIRECT:   stepCnt <= `STEP_EXEC1;
            pdp8Pkg::INDIRECT: stepCnt <= `STEP_IND;
            default:           stepCnt <= `STEP_AUTO1;
          endcase
        end else if (stepCnt == `STEP_LAST) begin
          stepCnt <= `STEP_FETCH;   // No done by EXEC6, start over
        end else begin
          stepCnt <= stepCnt + 5'd1;
        end
      end
    end
  end

  // Phase is the step pair, strobe the odd step of the pair
  always_comb begin
    if (stepCnt <= `STEP_LAST)
      phase = pdp8Pkg::phase_t'(stepCnt[4:1]);
    else
      phase = pdp8Pkg::IDLE;
  end

  assign strobe = stepCnt[0] & (stepCnt <= `STEP_LAST);

endmodule

// ==== rtl/instDecode.sv ====
/* Instruction register and decoder. Turns the phase and opcode into memory
   actions and register load enables, and flags the end of each instruction. */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module instDecode (
  input  logic               SYSCLK,
  input  logic               RESET,
  input  pdp8Pkg::phase_t    phase,
  input  logic               strobe,
  input  pdp8Pkg::word_t     mb,
  input  logic               skipCond,
  input  logic               mbZeroNext,
  output pdp8Pkg::seqType_t  seqType,
  output pdp8Pkg::memAct_t   memAct,
  output pdp8Pkg::wrSrc_t    wrSrc,
  output pdp8Pkg::maSrc_t    maSrc,
  output logic               maLoad,
  output logic               pcLoad,
  output logic               pcInc,
  output logic               pcSkip,
  output logic               acAnd,
  output logic               acTad,
  output logic               acClear,
  output logic               oprExec,
  output logic               halt,
  output logic               done,
  output pdp8Pkg::word_t     ir
);

  pdp8Pkg::word_t inst;
  logic [2:0]     opcode;
  logic           group2;
  logic           oneExec;    // Single execute phase
  logic           autoAddr;
  logic           hltReq;

  always_ff @(posedge SYSCLK) begin
    if (RESET)
      ir <= '0;
    else if (strobe && phase == pdp8Pkg::FETCH)
      ir <= mb;
  end

  // During fetch the new instruction is still in MB
  assign inst     = (phase == pdp8Pkg::FETCH) ? mb : ir;
  assign opcode   = ir[11:9];
  assign group2   = ir[8] & ~ir[0];
  assign oneExec  = (opcode == `OP_DCA) || (opcode == `OP_JMP) || (opcode[2:1] == 2'b11);
  assign autoAddr = !inst[7] && ({5'b0, inst[6:0]} >= `AUTO_LO)
                    && ({5'b0, inst[6:0]} <= `AUTO_HI);

  always_comb begin
    if (inst[11:10] == 2'b11 || !inst[8])
      seqType = pdp8Pkg::DIRECT;       // IOT and OPR use bit 8 as a micro-op
    else if (autoAddr)
      seqType = pdp8Pkg::AUTOINDEX;
    else
      seqType = pdp8Pkg::INDIRECT;
  end

  always_comb begin
    memAct  = pdp8Pkg::NONE;
    wrSrc   = pdp8Pkg::WR_AC;
    maSrc   = pdp8Pkg::MA_PC;
    maLoad  = 1'b0;
    pcLoad  = 1'b0;
    pcInc   = 1'b0;
    pcSkip  = 1'b0;
    acAnd   = 1'b0;
    acTad   = 1'b0;
    acClear = 1'b0;
    oprExec = 1'b0;
    hltReq  = 1'b0;
    case (phase)
      pdp8Pkg::FETCH: begin
        memAct = pdp8Pkg::READ;
        pcInc  = 1'b1;
        maLoad = 1'b1;
        maSrc  = pdp8Pkg::MA_ADDR;
      end
      pdp8Pkg::AUTO1: memAct = pdp8Pkg::READ;    // Read the pointer
      pdp8Pkg::AUTO2: begin
        memAct = pdp8Pkg::WRITE;                 // Write it back plus one
        wrSrc  = pdp8Pkg::WR_MBINC;
      end
      pdp8Pkg::IND: begin
        memAct = pdp8Pkg::READ;
        maLoad = 1'b1;
        maSrc  = pdp8Pkg::MA_MB;
      end
      pdp8Pkg::EXEC1: begin
        maLoad = oneExec;                        // Point MA at the next fetch
        case (opcode)
          `OP_AND, `OP_TAD, `OP_ISZ: memAct = pdp8Pkg::READ;
          `OP_DCA: begin
            memAct  = pdp8Pkg::WRITE;
            acClear = 1'b1;
          end
          `OP_JMS: begin
            memAct = pdp8Pkg::WRITE;             // Return address
            wrSrc  = pdp8Pkg::WR_PC;
          end
          `OP_JMP: pcLoad = 1'b1;
          `OP_OPR: begin
            oprExec = 1'b1;
            pcSkip  = group2 & skipCond;
            hltReq  = group2 & ir[1];
          end
          default: ;                             // IOT acts as a no-op
        endcase
      end
      pdp8Pkg::EXEC2: begin
        maLoad = 1'b1;
        case (opcode)
          `OP_AND: acAnd = 1'b1;
          `OP_TAD: acTad = 1'b1;
          `OP_ISZ: begin
            memAct = pdp8Pkg::WRITE;
            wrSrc  = pdp8Pkg::WR_MBINC;
            pcSkip = mbZeroNext;
          end
          `OP_JMS: pcLoad = 1'b1;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  assign done = strobe & (((phase == pdp8Pkg::EXEC1) & oneExec)
                        | ((phase == pdp8Pkg::EXEC2) & ~oneExec));
  assign halt = strobe & hltReq;

endmodule

// ==== rtl/coreMemory.sv ====
/* 4K word core memory with the memory buffer register. Serves the core
   while running and the host load and examine port while stopped. */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module coreMemory (
  input  logic              SYSCLK,
  input  logic              RESET,
  input  pdp8Pkg::memAct_t  memAct,
  input  pdp8Pkg::wrSrc_t   wrSrc,
  input  logic              strobe,
  input  pdp8Pkg::addr_t    ma,
  input  pdp8Pkg::word_t    ac,
  input  pdp8Pkg::word_t    pc,
  input  logic              running,
  output pdp8Pkg::word_t    mb,
  output logic              mbZeroNext,
  input  logic              loadValid,
  output logic              loadReady,
  input  pdp8Pkg::addr_t    loadAddr,
  input  pdp8Pkg::word_t    loadData,
  input  logic              examValid,
  output logic              examReady,
  input  pdp8Pkg::addr_t    examAddr,
  output pdp8Pkg::word_t    examData,
  output logic              examDataValid
);

  pdp8Pkg::word_t mem [`MEM_DEPTH];
  pdp8Pkg::word_t wrData;
  logic           loadFire;
  logic           examFire;

  assign loadReady  = ~running;
  assign examReady  = ~running & ~loadValid;   // Load wins
  assign loadFire   = loadValid & loadReady;
  assign examFire   = examValid & examReady;
  assign mbZeroNext = (mb == {`WORD_W{1'b1}});
  assign examData   = mb;

  always_comb begin
    case (wrSrc)
      pdp8Pkg::WR_MBINC: wrData = mb + 1'b1;
      pdp8Pkg::WR_PC:    wrData = pc;
      default:           wrData = ac;
    endcase
  end

  always_ff @(posedge SYSCLK) begin
    if (loadFire)
      mem[loadAddr] <= loadData;
    else if (memAct == pdp8Pkg::WRITE && strobe)
      mem[ma] <= wrData;
  end

  // Reads land in MB by the strobe cycle
  always_ff @(posedge SYSCLK) begin
    if (RESET) begin
      mb            <= '0;
      examDataValid <= 1'b0;
    end else begin
      examDataValid <= examFire;
      if (examFire)
        mb <= mem[examAddr];
      else if (memAct == pdp8Pkg::READ && !strobe)
        mb <= mem[ma];
    end
  end

endmodule

// ==== rtl/addressUnit.sv ====
/* Program counter and memory address register. Builds page-relative
   addresses, follows pointers and applies increments, skips and jumps. */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module addressUnit (
  input  logic              SYSCLK,
  input  logic              RESET,
  input  logic              strobe,
  input  pdp8Pkg::word_t    ir,
  input  pdp8Pkg::word_t    mb,
  input  pdp8Pkg::maSrc_t   maSrc,
  input  logic              maLoad,
  input  logic              pcLoad,
  input  logic              pcInc,
  input  logic              pcSkip,
  output pdp8Pkg::addr_t    pc,
  output pdp8Pkg::addr_t    ma
);

  pdp8Pkg::addr_t effAddr;
  pdp8Pkg::addr_t pcNext;
  pdp8Pkg::addr_t maNext;
  logic           isJms;

  assign isJms = (ir[11:9] == `OP_JMS);

  // Page bit selects current page of PC, else page zero
  assign effAddr = mb[7] ? {pc[11:7], mb[6:0]} : {5'b0, mb[6:0]};

  always_comb begin
    if (pcLoad)
      pcNext = isJms ? ma + 1'b1 : ma;   // JMS continues past the stored link
    else if (pcInc || pcSkip)
      pcNext = pc + 1'b1;
    else
      pcNext = pc;
  end

  always_comb begin
    case (maSrc)
      pdp8Pkg::MA_ADDR: maNext = effAddr;
      pdp8Pkg::MA_MB:   maNext = mb;
      default:          maNext = pcNext;   // Next fetch address
    endcase
  end

  always_ff @(posedge SYSCLK) begin
    if (RESET) begin
      pc <= '0;
      ma <= '0;
    end else if (strobe) begin
      pc <= pcNext;
      if (maLoad)
        ma <= maNext;
    end
  end

endmodule

// ==== rtl/accumulatorAlu.sv ====
/* Accumulator and link with the AND and TAD datapath, the group 1 operate
   micro-ops and the group 2 skip test. Updates on the phase strobe. */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module accumulatorAlu (
  input  logic            SYSCLK,
  input  logic            RESET,
  input  logic            strobe,
  input  pdp8Pkg::word_t  mb,
  input  pdp8Pkg::word_t  ir,
  input  logic            acAnd,
  input  logic            acTad,
  input  logic            acClear,
  input  logic            oprExec,
  output pdp8Pkg::word_t  ac,
  output logic            link,
  output logic            skipCond
);

  logic [`WORD_W:0] lacOpr;     // {link, ac} after operate micro-ops
  logic             group2;
  logic             skipRaw;

  assign group2 = ir[8] & ~ir[0];

  // Group 1 order is clear, complement, increment, rotate
  always_comb begin
    lacOpr = {link, ac};
    if (!ir[8]) begin
      if (ir[7])
        lacOpr[`WORD_W-1:0] = '0;                     // CLA
      if (ir[6])
        lacOpr[`WORD_W] = 1'b0;                       // CLL
      if (ir[5])
        lacOpr[`WORD_W-1:0] = ~lacOpr[`WORD_W-1:0];   // CMA
      if (ir[4])
        lacOpr[`WORD_W] = ~lacOpr[`WORD_W];           // CML
      if (ir[0])
        lacOpr = lacOpr + 1'b1;                       // IAC, carry flips link
      if (ir[3])
        lacOpr = {lacOpr[0], lacOpr[`WORD_W:1]};      // RAR
      else if (ir[2])
        lacOpr = {lacOpr[`WORD_W-1:0], lacOpr[`WORD_W]};  // RAL
    end else if (group2 && ir[7]) begin
      lacOpr[`WORD_W-1:0] = '0;   // Group 2 CLA comes after the skip test
    end
  end

  // SMA, SZA, SNL; bit 3 inverts the sense, alone it is SKP
  assign skipRaw  = (ir[6] & ac[`WORD_W-1]) | (ir[5] & (ac == '0)) | (ir[4] & link);
  assign skipCond = group2 & (skipRaw ^ ir[3]);

  always_ff @(posedge SYSCLK) begin
    if (RESET) begin
      ac   <= '0;
      link <= 1'b0;
    end else if (strobe) begin
      if (acAnd)
        ac <= ac & mb;
      else if (acTad)
        {link, ac} <= {link, ac} + {1'b0, mb};   // Carry out flips link
      else if (acClear)
        ac <= '0;                                // DCA
      else if (oprExec)
        {link, ac} <= lacOpr;
    end
  end

endmodule

// ==== rtl/pdp8Core.sv ====
/* Top level of the PDP-8 core. Connects the sequencer, the decoder and the
   datapath blocks, and exposes the host memory port and the register view. */
`timescale 1ns/1ps

module pdp8Core (
  input  logic            SYSCLK,
  input  logic            RESET,
  input  logic            run,
  input  logic            halt,
  input  logic            loadValid,
  output logic            loadReady,
  input  pdp8Pkg::addr_t  loadAddr,
  input  pdp8Pkg::word_t  loadData,
  input  logic            examValid,
  output logic            examReady,
  input  pdp8Pkg::addr_t  examAddr,
  output pdp8Pkg::word_t  examData,
  output logic            examDataValid,
  output pdp8Pkg::word_t  ac,
  output logic            link,
  output pdp8Pkg::addr_t  pc,
  output logic            running
);

  pdp8Pkg::phase_t   phase;
  pdp8Pkg::seqType_t seqType;
  pdp8Pkg::memAct_t  memAct;
  pdp8Pkg::wrSrc_t   wrSrc;
  pdp8Pkg::maSrc_t   maSrc;
  pdp8Pkg::word_t    ir;
  pdp8Pkg::word_t    mb;
  pdp8Pkg::addr_t    ma;
  logic              strobe;
  logic              done;
  logic              hltInst;
  logic              seqHalt;
  logic              maLoad;
  logic              pcLoad;
  logic              pcInc;
  logic              pcSkip;
  logic              acAnd;
  logic              acTad;
  logic              acClear;
  logic              oprExec;
  logic              skipCond;
  logic              mbZeroNext;

  assign seqHalt = halt | hltInst;   // Front panel halt or HLT instruction

  sequencer uSequencer (
    .SYSCLK(SYSCLK), .RESET(RESET), .run(run), .halt(seqHalt), .done(done),
    .seqType(seqType), .phase(phase), .strobe(strobe), .running(running)
  );

  instDecode uDecode (
    .SYSCLK(SYSCLK), .RESET(RESET), .phase(phase), .strobe(strobe), .mb(mb),
    .skipCond(skipCond), .mbZeroNext(mbZeroNext), .seqType(seqType),
    .memAct(memAct), .wrSrc(wrSrc), .maSrc(maSrc), .maLoad(maLoad),
    .pcLoad(pcLoad), .pcInc(pcInc), .pcSkip(pcSkip), .acAnd(acAnd),
    .acTad(acTad), .acClear(acClear), .oprExec(oprExec), .halt(hltInst),
    .done(done), .ir(ir)
  );

  coreMemory uMemory (
    .SYSCLK(SYSCLK), .RESET(RESET), .memAct(memAct), .wrSrc(wrSrc),
    .strobe(strobe), .ma(ma), .ac(ac), .pc(pc), .running(running), .mb(mb),
    .mbZeroNext(mbZeroNext), .loadValid(loadValid), .loadReady(loadReady),
    .loadAddr(loadAddr), .loadData(loadData), .examValid(examValid),
    .examReady(examReady), .examAddr(examAddr), .examData(examData),
    .examDataValid(examDataValid)
  );

  addressUnit uAddress (
    .SYSCLK(SYSCLK), .RESET(RESET), .strobe(strobe), .ir(ir), .mb(mb),
    .maSrc(maSrc), .maLoad(maLoad), .pcLoad(pcLoad), .pcInc(pcInc),
    .pcSkip(pcSkip), .pc(pc), .ma(ma)
  );

  accumulatorAlu uAlu (
    .SYSCLK(SYSCLK), .RESET(RESET), .strobe(strobe), .mb(mb), .ir(ir),
    .acAnd(acAnd), .acTad(acTad), .acClear(acClear), .oprExec(oprExec),
    .ac(ac), .link(link), .skipCond(skipCond)
  );

endmodule

// ==== test/pdp8Core_asserts.sv ====
/* Concurrent checks on the sequencer outputs and the host load port.
   Bound into the core top level, where both sets of signals meet. */
`timescale 1ns/1ps

module pdp8CoreAsserts (
  input logic            SYSCLK,
  input logic            RESET,
  input logic            running,
  input logic            strobe,
  input logic            done,
  input pdp8Pkg::phase_t phase,
  input logic            loadReady
);

  // Two cycles per phase, strobe on the second
  strobeRise: assert property (@(posedge SYSCLK) disable iff (RESET)
    running && !strobe |=> strobe)
    else $error("strobe stayed low for two cycles while running");

  strobeFall: assert property (@(posedge SYSCLK) disable iff (RESET)
    running && strobe |=> !strobe)
    else $error("strobe stayed high for two cycles while running");

  // Step counter restarts or stops after the last execute strobe
  doneRestartsFetch: assert property (@(posedge SYSCLK) disable iff (RESET)
    done |=> (phase == pdp8Pkg::FETCH) || (phase == pdp8Pkg::IDLE))
    else $error("done not followed by FETCH or IDLE");

  idleWhenStopped: assert property (@(posedge SYSCLK) disable iff (RESET)
    !running |-> phase == pdp8Pkg::IDLE)
    else $error("phase not IDLE while stopped");

  loadOpensAtDone: assert property (@(posedge SYSCLK) disable iff (RESET)
    $rose(loadReady) |-> $past(done))   // Core stops only at an instruction end
    else $error("load port opened outside the end of an instruction");

endmodule

bind pdp8Core pdp8CoreAsserts uAsserts (
  .SYSCLK(SYSCLK), .RESET(RESET), .running(running), .strobe(strobe),
  .done(done), .phase(phase), .loadReady(loadReady)
);

// ==== test/pdp8CoreTb.sv ====
/* Directed testbench for the PDP-8 core. Loads small programs through the host
   port, runs them to HLT and checks memory and registers against expected values. */
`timescale 1ns/1ps

module pdp8CoreTb;

  localparam int STOP_TIMEOUT = 4000;   // Cycles allowed for a program to halt
  localparam int PORT_TIMEOUT = 50;

  logic           SYSCLK;
  logic           RESET;
  logic           run;
  logic           halt;
  logic           loadValid;
  logic           loadReady;
  pdp8Pkg::addr_t loadAddr;
  pdp8Pkg::word_t loadData;
  logic           examValid;
  logic           examReady;
  pdp8Pkg::addr_t examAddr;
  pdp8Pkg::word_t examData;
  logic           examDataValid;
  pdp8Pkg::word_t ac;
  logic           link;
  pdp8Pkg::addr_t pc;
  logic           running;

  int             checkCount;
  int             errCount;
  int             testErrStart;
  logic [31:0]    rngState;
  pdp8Pkg::word_t prog[$];            // Program image, loaded from address base

  pdp8Core dut_i (
    .SYSCLK(SYSCLK), .RESET(RESET), .run(run), .halt(halt),
    .loadValid(loadValid), .loadReady(loadReady), .loadAddr(loadAddr),
    .loadData(loadData), .examValid(examValid), .examReady(examReady),
    .examAddr(examAddr), .examData(examData), .examDataValid(examDataValid),
    .ac(ac), .link(link), .pc(pc), .running(running)
  );

  always #10 SYSCLK = ~SYSCLK;

  function automatic pdp8Pkg::word_t randWord();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[11:0];
  endfunction

  task automatic compareValues(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0t ns: %s, got %0o expected %0o", $time, what, got, exp);
    end
  endtask

  task automatic timeoutError(input string what);
    errCount++;
    $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
  endtask

  task automatic reportTest(input string name);
    $display("Test %s finished with %0d errors", name, errCount - testErrStart);
    testErrStart = errCount;
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge SYSCLK);
    #1;
  endtask

  task automatic resetCore();
    RESET = 1'b1;
    repeat (2) @(posedge SYSCLK);
    #1 RESET = 1'b0;
  endtask

  task automatic loadWord(input pdp8Pkg::addr_t addr, input pdp8Pkg::word_t data);
    int waitCnt;
    loadValid = 1'b1;
    loadAddr  = addr;
    loadData  = data;
    waitCnt   = 0;
    while (!loadReady && waitCnt < PORT_TIMEOUT) begin
      nextCycle();
      waitCnt++;
    end
    if (!loadReady)
      timeoutError("load ready");
    nextCycle();                      // Word written on this edge
    loadValid = 1'b0;
  endtask

  task automatic examWord(input pdp8Pkg::addr_t addr, output pdp8Pkg::word_t data);
    int waitCnt;
    examValid = 1'b1;
    examAddr  = addr;
    waitCnt   = 0;
    while (!examReady && waitCnt < PORT_TIMEOUT) begin
      nextCycle();
      waitCnt++;
    end
    if (!examReady)
      timeoutError("examine ready");
    nextCycle();
    examValid = 1'b0;
    // Data follows one cycle after acceptance
    compareValues(examDataValid, 1, "examine data valid");
    data = examData;
  endtask

  task automatic expectMem(input pdp8Pkg::addr_t addr, input pdp8Pkg::word_t exp,
                           input string what);
    pdp8Pkg::word_t got;
    examWord(addr, got);
    compareValues(got, exp, what);
  endtask

  task automatic loadProgram(input pdp8Pkg::addr_t base);
    foreach (prog[i])
      loadWord(base + 12'(i), prog[i]);
  endtask

  task automatic startCore();
    run = 1'b1;
    nextCycle();
    run = 1'b0;
    compareValues(running, 1, "running after run edge");
  endtask

  task automatic waitStop(input string what);
    int waitCnt;
    waitCnt = 0;
    while (running && waitCnt < STOP_TIMEOUT) begin
      nextCycle();
      waitCnt++;
    end
    if (running)
      timeoutError({what, " to stop"});
  endtask

  task automatic runProgram(input string what);
    startCore();
    waitStop(what);
  endtask

  task automatic loadAndExamine();
    pdp8Pkg::word_t expWords[8];
    pdp8Pkg::word_t got;
    pdp8Pkg::addr_t base;
    compareValues(running, 0, "running after reset");
    compareValues(examDataValid, 0, "examine valid after reset");
    compareValues(loadReady, 1, "load ready while stopped");
    compareValues(examReady, 1, "examine ready while stopped");
    base = randWord() & 12'o7760;
    for (int i = 0; i < 8; i++) begin
      expWords[i] = randWord();
      loadWord(base + 12'(i), expWords[i]);
    end
    for (int i = 0; i < 8; i++) begin
      examWord(base + 12'(i), got);
      compareValues(got, expWords[i], "examined word");
    end
    compareValues(loadReady, 1, "load ready after transfers");
    reportTest("loadAndExamine");
  endtask

  task automatic addAndStore();
    pdp8Pkg::word_t a;
    pdp8Pkg::word_t b;
    logic [12:0]    sum;
    a   = randWord();
    b   = randWord();
    sum = {1'b0, a} + {1'b0, b};      // Carry out lands in the link
    resetCore();
    prog = '{12'o7200, 12'o1020, 12'o1021, 12'o3022, 12'o7402};  // CLA TAD TAD DCA HLT
    loadProgram(12'o0000);
    loadWord(12'o0020, a);
    loadWord(12'o0021, b);
    loadWord(12'o0022, 12'o0000);
    runProgram("sum program");
    expectMem(12'o0022, sum[11:0], "stored sum");
    compareValues(link, sum[12], "link after carry");
    compareValues(ac, 0, "AC after DCA");
    compareValues(pc, 12'o0005, "PC after HLT");
    reportTest("addAndStore");
  endtask

  task automatic indirectOperands();
    pdp8Pkg::word_t opA;
    pdp8Pkg::word_t opB;
    opA = randWord();
    opB = randWord();
    resetCore();
    // CLA CLL, TAD I 0020, DCA 0021, TAD I 0010, DCA 0022, HLT
    prog = '{12'o7300, 12'o1420, 12'o3021, 12'o1410, 12'o3022, 12'o7402};
    loadProgram(12'o0000);
    loadWord(12'o0010, 12'o0037);     // Auto-index pointer, used after increment
    loadWord(12'o0020, 12'o0030);
    loadWord(12'o0030, opA);
    loadWord(12'o0040, opB);
    runProgram("pointer program");
    expectMem(12'o0021, opA, "indirect operand");
    expectMem(12'o0022, opB, "auto-index operand");
    expectMem(12'o0010, 12'o0040, "auto-index location incremented");
    expectMem(12'o0020, 12'o0030, "plain pointer unchanged");
    compareValues(pc, 12'o0006, "PC after HLT");
    reportTest("indirectOperands");
  endtask

  task automatic jumpsAndLoop();
    pdp8Pkg::word_t x;
    pdp8Pkg::word_t expAc;
    int             n;
    x = randWord();
    n = (randWord() & 12'o0017) + 1;
    expAc = x + 12'(n);               // AC wraps at 12 bits
    resetCore();
    prog = '{
      12'o5003,                       // 0000 JMP 0003
      12'o7402,                       // 0001 HLT, jumped over
      12'o7402,
      12'o4050,                       // 0003 JMS 0050
      12'o7001,                       // 0004 IAC, loop body
      12'o2021,                       // 0005 ISZ count
      12'o5004,                       // 0006 JMP 0004
      12'o7402                        // 0007 HLT
    };
    loadProgram(12'o0000);
    loadWord(12'o0020, x);
    loadWord(12'o0021, 12'(4096 - n));
    loadWord(12'o0050, 12'o0000);     // Return address slot
    loadWord(12'o0051, 12'o1020);     // TAD 0020
    loadWord(12'o0052, 12'o5450);     // JMP I 0050
    runProgram("branch program");
    compareValues(ac, expAc, "AC after loop");
    expectMem(12'o0021, 12'o0000, "loop count at zero");
    expectMem(12'o0050, 12'o0004, "JMS return address");
    compareValues(pc, 12'o0010, "PC after HLT");
    reportTest("jumpsAndLoop");
  endtask

  task automatic operateMicroOps(input pdp8Pkg::word_t v);
    resetCore();
    prog = '{
      12'o7100, 12'o1140, 12'o7040, 12'o3141,   // CLL TAD CMA DCA
      12'o7100, 12'o1140, 12'o7001, 12'o3142,   // CLL TAD IAC DCA
      12'o7100, 12'o1140, 12'o7004, 12'o3143,   // CLL TAD RAL DCA
      12'o7420, 12'o2150,                       // SNL, flag if link clear
      12'o1140, 12'o7010, 12'o3144,             // TAD RAR DCA
      12'o7020, 12'o7420, 12'o2151,             // CML SNL, flag
      12'o1140, 12'o7440, 12'o2152,             // TAD SZA, flag
      12'o7500, 12'o2153,                       // SMA, flag
      12'o7450, 12'o2154,                       // SNA, flag
      12'o7402
    };
    loadProgram(12'o0000);
    loadWord(12'o0140, v);
    for (int i = 0; i < 5; i++)
      loadWord(12'o0150 + 12'(i), 12'o0000);
    runProgram("operate program");
    expectMem(12'o0141, ~v, "CMA");
    expectMem(12'o0142, v + 12'd1, "IAC");
    expectMem(12'o0143, {v[10:0], 1'b0}, "RAL");
    expectMem(12'o0144, {v[11], v[11:1]}, "RAR with link from RAL");
    // A flag stays zero when its ISZ was skipped
    expectMem(12'o0150, v[11] ? 12'o0000 : 12'o0001, "SNL after RAL");
    expectMem(12'o0151, v[0] ? 12'o0001 : 12'o0000, "SNL after CML");
    expectMem(12'o0152, (v == 12'o0000) ? 12'o0000 : 12'o0001, "SZA");
    expectMem(12'o0153, v[11] ? 12'o0000 : 12'o0001, "SMA");
    expectMem(12'o0154, (v != 12'o0000) ? 12'o0000 : 12'o0001, "SNA");
    compareValues(pc, 12'o0034, "PC after HLT");
    reportTest("operateMicroOps");
  endtask

  task automatic haltFromInput();
    int waitCnt;
    resetCore();
    loadWord(12'o0000, 12'o5000);     // JMP to self
    startCore();
    waitCnt = 0;
    while (running && waitCnt < 20) begin   // Let the loop spin a while
      nextCycle();
      waitCnt++;
    end
    compareValues(running, 1, "self loop still running");
    compareValues(loadReady, 0, "load ready while running");
    halt = 1'b1;
    nextCycle();
    halt = 1'b0;
    waitStop("halt input");
    compareValues(loadReady, 1, "load ready after halt");
    compareValues(pc, 12'o0000, "PC in self loop");
    reportTest("haltFromInput");
  endtask

  initial begin
    SYSCLK       = 1'b0;
    RESET        = 1'b1;
    run          = 1'b0;
    halt         = 1'b0;
    loadValid    = 1'b0;
    loadAddr     = '0;
    loadData     = '0;
    examValid    = 1'b0;
    examAddr     = '0;
    checkCount   = 0;
    errCount     = 0;
    testErrStart = 0;
    rngState     = 32'd84;
    resetCore();
    loadAndExamine();
    addAndStore();
    indirectOperands();
    jumpsAndLoop();
    operateMicroOps(randWord());
    operateMicroOps(12'o0000);
    operateMicroOps(randWord() | 12'o4000);   // Negative AC
    haltFromInput();
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/pdp8Pkg.sv
rtl/sequencer.sv
rtl/instDecode.sv
rtl/coreMemory.sv
rtl/addressUnit.sv
rtl/accumulatorAlu.sv
rtl/pdp8Core.sv
test/pdp8Core_asserts.sv
test/pdp8CoreTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = pdp8CoreTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED
SOURCES   = $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: fail"; exit 1; fi
	@if grep -q "Simulation exited with an error" $(LOG); then echo "Result: fail"; exit 1; fi
	@echo "Result: pass"

clean:
	rm -rf $(OBJDIR) $(LOG)
